// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = duck_hunt_tb
FILELIST = duck_hunt.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not pass"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== duck_hunt.f ====
src/duck_hunt_pkg.sv
src/sprite_if.sv
src/frame_timer.sv
src/flock_control.sv
src/bird_sprite.sv
src/hunter_sprite.sv
src/draw_sequencer.sv
src/duck_hunt_top.sv
test/duck_hunt_assertions.sv
test/duck_hunt_tb.sv

// ==== src/bird_sprite.sv ====
`timescale 1ns/1ps

module bird_sprite (
	input logic clock,
	input logic laser_on,
	sprite_if.drawer spr
);
	import duck_hunt_pkg::*;

	logic busy;
	logic [4:0] idx; // current table entry
	logic done_q;

	// head on the right, tail trails to the left
	function automatic x_t bird_dx(input logic [4:0] i);
		case (i)
			5'd0, 5'd1: bird_dx = x_t'(0);
			5'd2: bird_dx = x_t'(-1);
			5'd3: bird_dx = x_t'(-2);
			5'd4, 5'd7, 5'd8: bird_dx = x_t'(-3);
			5'd5, 5'd9, 5'd10: bird_dx = x_t'(-4);
			default: bird_dx = x_t'(-5); // body end and wing tips
		endcase
	endfunction

	// wings alternate below and above the body
	function automatic y_t bird_dy(input logic [4:0] i);
		case (i)
			5'd1, 5'd7: bird_dy = y_t'(1);
			5'd8: bird_dy = y_t'(-1);
			5'd9: bird_dy = y_t'(2);
			5'd10: bird_dy = y_t'(-2);
			5'd11: bird_dy = y_t'(3);
			5'd12: bird_dy = y_t'(-3);
			default: bird_dy = y_t'(0); // body row
		endcase
	endfunction

	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			busy <= 1'b0;
			idx <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				if (spr.start) begin
					busy <= 1'b1;
					idx <= '0;
				end
			end else if (spr.pix_ready) begin
				if (idx == BIRD_PIXELS - 5'd1) begin
					busy <= 1'b0;
					done_q <= 1'b1;
				end else begin
					idx <= idx + 5'd1; // next entry on accept
				end
			end
		end
	end

	assign spr.pix_valid = busy;
	assign spr.pix_x = spr.origin_x + bird_dx(idx);
	assign spr.pix_y = spr.origin_y + bird_dy(idx);
	assign spr.done = done_q;

endmodule

// ==== src/draw_sequencer.sv ====
`timescale 1ns/1ps

module draw_sequencer (
	input logic clock,
	input logic laser_on,
	input logic frame_tick,
	input duck_hunt_pkg::bird_mask_t bird_on,
	input duck_hunt_pkg::x_t bird_x [duck_hunt_pkg::NUM_BIRDS],
	sprite_if.sequencer bird_spr,
	sprite_if.sequencer hunter_spr,
	output logic advance,
	output logic [2:0] advance_bird,
	output logic frame_done,
	output logic pixel_valid,
	output duck_hunt_pkg::x_t pixel_x,
	output duck_hunt_pkg::y_t pixel_y,
	output duck_hunt_pkg::colour_t pixel_colour,
	input logic pixel_ready
);
	import duck_hunt_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ERASE,
		S_MOVE,
		S_DRAW,
		S_HUNTER,
		S_FINISH
	} state_t;

	state_t state;
	logic [2:0] bird_idx;
	logic launched; // drawer started for this state
	logic hunter_active;

	localparam logic [2:0] LAST_BIRD = 3'(NUM_BIRDS - 1);

	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			state <= S_IDLE;
			bird_idx <= '0;
			launched <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (frame_tick) begin // late ticks are dropped
					state <= S_ERASE;
					bird_idx <= '0;
					launched <= 1'b0;
				end
				S_ERASE: if (!launched) begin
					if (bird_on[bird_idx])
						launched <= 1'b1;
					else if (bird_idx == LAST_BIRD)
						state <= S_HUNTER; // skip disabled bird
					else
						bird_idx <= bird_idx + 3'd1;
				end else if (bird_spr.done) begin
					state <= S_MOVE;
					launched <= 1'b0;
				end
				S_MOVE: state <= S_DRAW;
				S_DRAW: if (!launched) begin
					launched <= 1'b1;
				end else if (bird_spr.done) begin
					launched <= 1'b0;
					if (bird_idx == LAST_BIRD) begin
						state <= S_HUNTER;
					end else begin
						state <= S_ERASE;
						bird_idx <= bird_idx + 3'd1;
					end
				end
				S_HUNTER: if (!launched) begin
					launched <= 1'b1;
				end else if (hunter_spr.done) begin
					state <= S_FINISH;
					launched <= 1'b0;
				end
				default: state <= S_IDLE; // finish
			endcase
		end
	end

	assign hunter_active = (state == S_HUNTER);

	assign bird_spr.start = !launched &&
		((state == S_ERASE && bird_on[bird_idx]) || state == S_DRAW);
	assign bird_spr.origin_x = bird_x[bird_idx];
	assign bird_spr.origin_y = BIRD_ROW[bird_idx];
	assign bird_spr.colour = (state == S_ERASE) ? COLOUR_BLACK : COLOUR_WHITE;
	assign bird_spr.pix_ready = pixel_ready && !hunter_active;

	assign hunter_spr.start = hunter_active && !launched;
	assign hunter_spr.origin_x = HUNTER_X;
	assign hunter_spr.origin_y = HUNTER_Y;
	assign hunter_spr.colour = COLOUR_HUNTER;
	assign hunter_spr.pix_ready = pixel_ready && hunter_active;

	assign advance = (state == S_MOVE); // between erase and draw
	assign advance_bird = bird_idx;
	assign frame_done = (state == S_FINISH);

	// only the active drawer reaches the pixel port
	assign pixel_valid = hunter_active ? hunter_spr.pix_valid : bird_spr.pix_valid;
	assign pixel_x = hunter_active ? hunter_spr.pix_x : bird_spr.pix_x;
	assign pixel_y = hunter_active ? hunter_spr.pix_y : bird_spr.pix_y;
	assign pixel_colour = hunter_active ? hunter_spr.colour : bird_spr.colour;

endmodule

// ==== src/duck_hunt_pkg.sv ====
package duck_hunt_pkg;

	typedef logic [7:0] x_t; // column, wraps mod 256
	typedef logic [6:0] y_t; // row, wraps mod 128
	typedef logic [2:0] colour_t;

	localparam int NUM_BIRDS = 7;

	typedef logic [NUM_BIRDS-1:0] bird_mask_t; // one enable per bird

	localparam colour_t COLOUR_BLACK = 3'd0;
	localparam colour_t COLOUR_WHITE = 3'd7;
	localparam colour_t COLOUR_HUNTER = 3'd2;

	// short frame so a simulation run stays quick
	localparam logic [19:0] FRAME_CYCLES = 20'd600;
	localparam logic [5:0] LEVEL_FRAMES = 6'd4; // frames per extra bird

	localparam x_t BIRD_START_X = 8'd5;

	// fixed flight row of every bird
	localparam y_t BIRD_ROW [NUM_BIRDS] = '{
		7'd10,
		7'd25,
		7'd40,
		7'd55,
		7'd70,
		7'd85,
		7'd100
	};

	localparam x_t HUNTER_X = 8'd75; // centre column
	localparam y_t HUNTER_Y = 7'd115; // top row

	localparam logic [4:0] BIRD_PIXELS = 5'd13;
	localparam logic [4:0] HUNTER_PIXELS = 5'd22;

endpackage

// ==== src/duck_hunt_top.sv ====
`timescale 1ns/1ps

module duck_hunt_top (
	input logic clock,
	input logic laser_on,
	input logic pixel_ready,
	output logic pixel_valid,
	output duck_hunt_pkg::x_t pixel_x,
	output duck_hunt_pkg::y_t pixel_y,
	output duck_hunt_pkg::colour_t pixel_colour,
	output logic frame_done,
	output logic [2:0] bird_count
);
	import duck_hunt_pkg::*;

	logic frame_tick;
	logic advance;
	logic [2:0] advance_bird;
	bird_mask_t bird_on;
	x_t bird_x [NUM_BIRDS];

	sprite_if bird_bus ();
	sprite_if hunter_bus ();

	frame_timer u_frame_timer (
		.clock(clock),
		.laser_on(laser_on),
		.frame_tick(frame_tick)
	);

	flock_control u_flock_control (
		.clock(clock),
		.laser_on(laser_on),
		.advance(advance),
		.advance_bird(advance_bird),
		.frame_done(frame_done),
		.bird_on(bird_on),
		.bird_x(bird_x),
		.bird_count(bird_count)
	);

	bird_sprite u_bird_sprite (.clock(clock), .laser_on(laser_on), .spr(bird_bus.drawer));

	hunter_sprite u_hunter_sprite (.clock(clock), .laser_on(laser_on), .spr(hunter_bus.drawer));

	draw_sequencer u_draw_sequencer (
		.clock(clock),
		.laser_on(laser_on),
		.frame_tick(frame_tick),
		.bird_on(bird_on),
		.bird_x(bird_x),
		.bird_spr(bird_bus.sequencer),
		.hunter_spr(hunter_bus.sequencer),
		.advance(advance),
		.advance_bird(advance_bird),
		.frame_done(frame_done),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour),
		.pixel_ready(pixel_ready)
	);

endmodule

// ==== src/flock_control.sv ====
`timescale 1ns/1ps

module flock_control (
	input logic clock,
	input logic laser_on,
	input logic advance,
	input logic [2:0] advance_bird,
	input logic frame_done,
	output duck_hunt_pkg::bird_mask_t bird_on,
	output duck_hunt_pkg::x_t bird_x [duck_hunt_pkg::NUM_BIRDS],
	output logic [2:0] bird_count
);
	import duck_hunt_pkg::*;

	logic [5:0] level_frames; // finished frames in this level

	// column of each bird, only the addressed one steps
	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			for (int i = 0; i < NUM_BIRDS; i++) begin
				bird_x[i] <= BIRD_START_X;
			end
		end else if (advance) begin
			for (int i = 0; i < NUM_BIRDS; i++) begin
				if (3'(i) == advance_bird)
					bird_x[i] <= bird_x[i] + 8'd1; // wraps at 256
			end
		end
	end

	// level counter
	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			level_frames <= '0;
			bird_count <= 3'd1;
		end else if (frame_done) begin
			if (level_frames == LEVEL_FRAMES - 6'd1) begin
				level_frames <= '0;
				if (bird_count != 3'(NUM_BIRDS))
					bird_count <= bird_count + 3'd1;
			end else begin
				level_frames <= level_frames + 6'd1;
			end
		end
	end

	// thermometer mask, lowest birds fly first
	always_comb begin
		for (int i = 0; i < NUM_BIRDS; i++) begin
			bird_on[i] = (3'(i) < bird_count);
		end
	end

endmodule

// ==== src/frame_timer.sv ====
`timescale 1ns/1ps

module frame_timer (
	input logic clock,
	input logic laser_on,
	output logic frame_tick
);
	import duck_hunt_pkg::*;

	logic [19:0] count;
	logic tick_q;

	// counts down once per cycle, reload on zero
	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			count <= FRAME_CYCLES - 20'd1;
			tick_q <= 1'b0;
		end else begin
			if (count == 20'd0) begin
				count <= FRAME_CYCLES - 20'd1;
				tick_q <= 1'b1; // one pulse per frame
			end else begin
				count <= count - 20'd1;
				tick_q <= 1'b0;
			end
		end
	end

	assign frame_tick = tick_q;

endmodule

// ==== src/hunter_sprite.sv ====
`timescale 1ns/1ps

module hunter_sprite (
	input logic clock,
	input logic laser_on,
	sprite_if.drawer spr
);
	import duck_hunt_pkg::*;

	logic busy;
	logic [4:0] idx;
	logic done_q;

	// left to right within a row
	function automatic x_t hunter_dx(input logic [4:0] i);
		case (i)
			5'd0, 5'd3, 5'd8, 5'd15: hunter_dx = x_t'(-1);
			5'd1, 5'd4, 5'd9, 5'd16: hunter_dx = x_t'(0);
			5'd2, 5'd5, 5'd10, 5'd17: hunter_dx = x_t'(1);
			5'd6, 5'd13, 5'd20: hunter_dx = x_t'(-3); // left edge and foot
			5'd7, 5'd14: hunter_dx = x_t'(-2);
			5'd11, 5'd18: hunter_dx = x_t'(2);
			default: hunter_dx = x_t'(3);
		endcase
	endfunction

	// rows top to bottom
	function automatic y_t hunter_dy(input logic [4:0] i);
		y_t dy;
		if (i < 5'd3)
			dy = y_t'(0); // head
		else if (i < 5'd6)
			dy = y_t'(1);
		else if (i < 5'd13)
			dy = y_t'(2); // body
		else if (i < 5'd20)
			dy = y_t'(3);
		else
			dy = y_t'(4); // feet
		return dy;
	endfunction

	always_ff @(posedge clock or posedge laser_on) begin
		if (laser_on) begin
			busy <= 1'b0;
			idx <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				if (spr.start) begin
					busy <= 1'b1;
					idx <= '0;
				end
			end else if (spr.pix_ready) begin
				if (idx == HUNTER_PIXELS - 5'd1) begin
					busy <= 1'b0;
					done_q <= 1'b1;
				end else begin
					idx <= idx + 5'd1;
				end
			end
		end
	end

	// hunter stands still, origin from the shared constants
	assign spr.pix_valid = busy;
	assign spr.pix_x = HUNTER_X + hunter_dx(idx);
	assign spr.pix_y = HUNTER_Y + hunter_dy(idx);
	assign spr.done = done_q;

endmodule

// ==== src/sprite_if.sv ====
`timescale 1ns/1ps

interface sprite_if;
	import duck_hunt_pkg::*;

	logic start; // pulse, drawer idle
	x_t origin_x;
	y_t origin_y;
	colour_t colour; // held for the whole sprite
	logic pix_valid;
	x_t pix_x;
	y_t pix_y;
	logic pix_ready;
	logic done; // cycle after last accepted pixel

	modport drawer (input start, origin_x, origin_y, colour, pix_ready,
		output pix_valid, pix_x, pix_y, done);

	modport sequencer (output start, origin_x, origin_y, colour, pix_ready,
		input pix_valid, pix_x, pix_y, done);

endinterface

// ==== test/duck_hunt_assertions.sv ====
`timescale 1ns/1ps

module duck_hunt_assertions (
	input logic clock,
	input logic laser_on,
	input logic pixel_valid,
	input logic pixel_ready,
	input duck_hunt_pkg::x_t pixel_x,
	input duck_hunt_pkg::y_t pixel_y,
	input duck_hunt_pkg::colour_t pixel_colour,
	input logic frame_done
);

	int failures = 0; // failed assertions so far

	// a stalled pixel waits unchanged until accepted
	stall_hold: assert property (@(posedge clock) disable iff (laser_on)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_x)
			&& $stable(pixel_y) && $stable(pixel_colour))
		else begin
			failures++;
			$error("pixel changed while stalled");
		end

	frame_done_pulse: assert property (@(posedge clock) disable iff (laser_on)
		frame_done |=> !frame_done)
		else begin
			failures++;
			$error("frame_done longer than one cycle");
		end

	reset_quiet: assert property (@(posedge clock) $fell(laser_on) |-> !pixel_valid)
		else begin
			failures++;
			$error("pixel_valid high right after reset"); // drawers start idle
		end

endmodule

bind duck_hunt_top duck_hunt_assertions u_assertions (
	.clock(clock),
	.laser_on(laser_on),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.pixel_x(pixel_x),
	.pixel_y(pixel_y),
	.pixel_colour(pixel_colour),
	.frame_done(frame_done)
);

// ==== test/duck_hunt_tb.sv ====
`timescale 1ns/1ps

module duck_hunt_tb;
	import duck_hunt_pkg::*;

	localparam int MAX_PIXELS = NUM_BIRDS * 2 * int'(BIRD_PIXELS) + int'(HUNTER_PIXELS);
	localparam int BIRD_DX [13] = '{0, 0, -1, -2, -3, -4, -5, -3, -3, -4, -4, -5, -5};
	localparam int BIRD_DY [13] = '{0, 1, 0, 0, 0, 0, 0, 1, -1, 2, -2, 3, -3};
	// head, shoulders, two body rows, feet
	localparam int HUNTER_DX [22] = '{-1, 0, 1, -1, 0, 1, -3, -2, -1, 0, 1, 2, 3,
		-3, -2, -1, 0, 1, 2, 3, -3, 3};
	localparam int HUNTER_DY [22] = '{0, 0, 0, 1, 1, 1, 2, 2, 2, 2, 2, 2, 2,
		3, 3, 3, 3, 3, 3, 3, 4, 4};

	logic clock;
	logic laser_on;
	logic pixel_ready;
	logic pixel_valid;
	x_t pixel_x;
	y_t pixel_y;
	colour_t pixel_colour;
	logic frame_done;
	logic [2:0] bird_count;

	int test_frames [$];
	int test_mode [$];
	int test_pixels [$];
	int test_birds [$];
	int watchdog_cycles;
	bit loaded = 1'b0;
	logic [31:0] lcg_state;
	int errors;
	int failed_tests;
	x_t exp_x [$]; // expected stream of the current frame
	y_t exp_y [$];
	colour_t exp_c [$];
	int exp_pos;
	x_t model_x [NUM_BIRDS];
	int model_birds;
	int model_frames;

	duck_hunt_top dut (
		.clock(clock),
		.laser_on(laser_on),
		.pixel_ready(pixel_ready),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour),
		.frame_done(frame_done),
		.bird_count(bird_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		errors++;
	endtask

	task automatic expect_pixel(input int x, input int y, input colour_t c);
		exp_x.push_back(x_t'(x)); // wraps like the screen
		exp_y.push_back(y_t'(y));
		exp_c.push_back(c);
	endtask

	// erase, move and redraw each bird, then the hunter
	task automatic build_frame();
		exp_x.delete();
		exp_y.delete();
		exp_c.delete();
		exp_pos = 0;
		for (int i = 0; i < model_birds; i++) begin
			for (int k = 0; k < 13; k++)
				expect_pixel(int'(model_x[i]) + BIRD_DX[k], int'(BIRD_ROW[i]) + BIRD_DY[k],
					COLOUR_BLACK);
			model_x[i] = model_x[i] + 8'd1;
			for (int k = 0; k < 13; k++)
				expect_pixel(int'(model_x[i]) + BIRD_DX[k], int'(BIRD_ROW[i]) + BIRD_DY[k],
					COLOUR_WHITE);
		end
		for (int k = 0; k < 22; k++)
			expect_pixel(int'(HUNTER_X) + HUNTER_DX[k], int'(HUNTER_Y) + HUNTER_DY[k],
				COLOUR_HUNTER);
	endtask

	// drive after the edge, sample at the falling edge
	task automatic step_cycle(input int mode);
		@(posedge clock);
		#2;
		if (mode == 0) begin
			pixel_ready = 1'b1;
		end else begin
			lcg_state = lcg_next(lcg_state);
			pixel_ready = (lcg_state[17:16] != 2'b00); // high three cycles in four
		end
		@(negedge clock);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#2;
		laser_on = 1'b1;
		pixel_ready = 1'b1;
		repeat (2) @(posedge clock);
		#2;
		laser_on = 1'b0;
	endtask

	task automatic run_test(input int num, input int frames, input int mode, input int pixels,
		input int birds);
		int cycles;
		int accepted;
		int seen_frames;
		int errors_before;
		int assert_before;
		errors_before = errors;
		assert_before = dut.u_assertions.failures;
		apply_reset();
		for (int i = 0; i < NUM_BIRDS; i++)
			model_x[i] = BIRD_START_X;
		model_frames = 0;
		model_birds = 1;
		if (bird_count != 3'd1)
			report_mismatch("bird_count", 1, int'(bird_count));
		build_frame();
		cycles = 0;
		accepted = 0;
		seen_frames = 0;
		while (seen_frames < frames) begin
			step_cycle(mode);
			cycles++;
			if (cycles <= int'(FRAME_CYCLES) && pixel_valid)
				report_mismatch("pixel_valid", 0, 1); // before the first tick
			if (cycles <= int'(FRAME_CYCLES) && frame_done)
				report_mismatch("frame_done", 0, 1);
			if (pixel_valid && pixel_ready) begin
				accepted++;
				if (exp_pos >= exp_x.size()) begin
					$display("extra pixel at t=%0t after the frame was complete", $time);
					errors++;
				end else begin
					if (pixel_x != exp_x[exp_pos])
						report_mismatch("pixel_x", int'(exp_x[exp_pos]), int'(pixel_x));
					if (pixel_y != exp_y[exp_pos])
						report_mismatch("pixel_y", int'(exp_y[exp_pos]), int'(pixel_y));
					if (pixel_colour != exp_c[exp_pos])
						report_mismatch("pixel_colour", int'(exp_c[exp_pos]), int'(pixel_colour));
					exp_pos++;
				end
			end
			if (frame_done) begin
				if (exp_pos != exp_x.size()) begin
					$display("frame %0d ended after %0d of %0d pixels at t=%0t",
						seen_frames + 1, exp_pos, exp_x.size(), $time);
					errors++;
				end
				if (int'(bird_count) != model_birds)
					report_mismatch("bird_count", model_birds, int'(bird_count));
				seen_frames++;
				model_frames++;
				model_birds = 1 + model_frames / int'(LEVEL_FRAMES);
				if (model_birds > NUM_BIRDS)
					model_birds = NUM_BIRDS;
				build_frame();
			end
		end
		step_cycle(mode); // let the level counter settle
		if (accepted != pixels)
			report_mismatch("pixel total", pixels, accepted);
		if (int'(bird_count) != birds)
			report_mismatch("bird_count", birds, int'(bird_count));
		errors += dut.u_assertions.failures - assert_before; // bound checker
		if (errors == errors_before) begin
			$display("test %0d ok: %0d frames, ready mode %0d, %0d pixels", num, frames, mode,
				accepted);
		end else begin
			$display("test %0d failed with %0d errors", num, errors - errors_before);
			failed_tests++;
		end
	endtask

	initial begin
		wait (loaded);
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int fd;
		int f;
		int m;
		int p;
		int b;
		string line;
		laser_on = 1'b1;
		pixel_ready = 1'b0;
		lcg_state = 32'h97d086e8;
		errors = 0;
		failed_tests = 0;
		watchdog_cycles = 100;
		fd = $fopen("test/duck_hunt_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open test/duck_hunt_tests.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "%d %d %d %d", f, m, p, b) == 4) begin // comments skipped
					test_frames.push_back(f);
					test_mode.push_back(m);
					test_pixels.push_back(p);
					test_birds.push_back(b);
					watchdog_cycles += f * (int'(FRAME_CYCLES) + 4 * MAX_PIXELS) + 10;
				end
			end
			$fclose(fd);
			if (test_frames.size() == 0) begin
				$display("no tests found in test/duck_hunt_tests.txt");
				errors++;
			end
		end
		loaded = 1'b1;
		for (int t = 0; t < test_frames.size(); t++)
			run_test(t + 1, test_frames[t], test_mode[t], test_pixels[t], test_birds[t]);
		$display("%0d tests run, %0d failed, %0d errors", test_frames.size(), failed_tests,
			errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== test/duck_hunt_tests.txt ====
# columns: frames, ready mode (0 always high, 1 random), expected pixel total, final bird_count
# one test per line, decimal
1 0 48 1
4 0 192 2
4 1 192 2
9 0 588 3
9 1 588 3
28 0 3528 7
30 1 3936 7
